// ==== alu_stage.sv ====
module alu_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  exec_pkt_t exec_i,
    input  xlen_t     rs1_val_i,
    input  xlen_t     rs2_val_i,
    output commit_t   commit_o
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [5:0] shamt;
    xlen_t      result;

    assign op_a  = rs1_val_i;
    assign op_b  = exec_i.use_imm ? exec_i.imm : rs2_val_i;
    assign shamt = op_b[5:0];               // rv64 shift amount

    always_comb begin
        case (exec_i.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;     // logical
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // build the retire record
    always_comb begin
        commit_o.pc      = exec_i.pc;
        commit_o.instr   = exec_i.instr;
        commit_o.rd      = exec_i.rd_idx;
        commit_o.we      = exec_i.we;
        commit_o.illegal = exec_i.illegal;
        if (exec_i.illegal || exec_i.rd_idx == '0) begin
            commit_o.data = '0;             // nothing architectural to report
        end else begin
            commit_o.data = result;
        end
    end

endmodule

// ==== core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// core-wide widths

`define CORE_XLEN       64                  // integer register and datapath width
`define CORE_ILEN       32                  // base encoding only, no compressed

`define CORE_NREGS      32

// first fetch address out of reset
`define CORE_RESET_PC   64'h8000_0000

`endif

// ==== core_pipe_pkg.sv ====
package core_pipe_pkg;

    import rv_isa_pkg::*;

    // fetch latch to decode
    typedef struct packed {
        xlen_t    pc;
        instr_t   instr;
    } fetch_pkt_t;

    // decode to execute
    typedef struct packed {
        xlen_t    pc;
        instr_t   instr;
        alu_op_e  alu_op;
        xlen_t    rs1_val;                  // regfile value, may be overridden by forwarding
        xlen_t    rs2_val;
        xlen_t    imm;
        logic     use_imm;                  // operand b from imm instead of rs2
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        reg_idx_t rd_idx;
        logic     we;
        logic     illegal;
    } exec_pkt_t;

    // retire record, also the writeback payload
    typedef struct packed {
        xlen_t    pc;
        instr_t   instr;
        reg_idx_t rd;
        logic     we;
        xlen_t    data;
        logic     illegal;
    } commit_t;

endpackage

// ==== core_props.sv ====
module core_props import rv_isa_pkg::*, core_pipe_pkg::*; (
    input logic    clk,
    input logic    rst_i,
    input logic    instr_valid_i,
    input logic    commit_valid_i,
    input commit_t commit_i
);

    xlen_t last_pc;
    logic  seen_commit;                     // at least one retire since reset

    always_ff @(posedge clk) begin
        if (rst_i) begin
            seen_commit <= 1'b0;
            last_pc     <= '0;
        end else if (commit_valid_i) begin
            seen_commit <= 1'b1;
            last_pc     <= commit_i.pc;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) rst_i |=> !commit_valid_i)
        else $error("commit valid set in the cycle after reset");

    // fetch at edge n shows up as a retire sampled at edge n+3
    a_fetch_to_commit: assert property (@(posedge clk) disable iff (rst_i)
        (!$past(rst_i, 1) && !$past(rst_i, 2) && !$past(rst_i, 3))
            |-> (commit_valid_i == $past(instr_valid_i, 3)))
        else $error("commit valid does not follow the fetch by three cycles");

    a_pc_step: assert property (@(posedge clk) disable iff (rst_i)
        (commit_valid_i && seen_commit) |-> (commit_i.pc == last_pc + xlen_t'(4)))
        else $error("retired pc did not step by 4 from the previous retire");

endmodule

bind core_top core_props core_props_inst (
    .clk(clk),
    .rst_i(rst_i),
    .instr_valid_i(instr_valid_i),
    .commit_valid_i(commit_valid_o),
    .commit_i(commit_o)
);

// ==== core_stimulus.txt ====
# gap  instr     rd  data              illegal  a0_after
# gap counts idle cycles before the instruction; rd, gap, illegal decimal, the rest hex
0 00500093  1 0000000000000005 0 0000000000000000
0 ffd00113  2 fffffffffffffffd 0 0000000000000000
0 002081b3  3 0000000000000002 0 0000000000000000
0 40208233  4 0000000000000008 0 0000000000000000
0 0020f2b3  5 0000000000000005 0 0000000000000000
0 0020e333  6 fffffffffffffffd 0 0000000000000000
0 0020c3b3  7 fffffffffffffff8 0 0000000000000000
0 00109433  8 00000000000000a0 0 0000000000000000
0 001154b3  9 07ffffffffffffff 0 0000000000000000
0 12345537 10 0000000012345000 0 0000000012345000
0 67856593 11 0000000012345678 0 0000000012345000
0 0ff5f613 12 0000000000000078 0 0000000012345000
0 fff64693 13 ffffffffffffff87 0 0000000012345000
0 80000737 14 ffffffff80000000 0 0000000012345000
0 00100793 15 0000000000000001 0 0000000012345000
0 00f787b3 15 0000000000000002 0 0000000012345000
0 00f787b3 15 0000000000000004 0 0000000012345000
0 00f79833 16 0000000000000040 0 0000000012345000
0 40f808b3 17 000000000000003c 0 0000000012345000
0 01088533 10 000000000000007c 0 000000000000007c
3 06450913 18 00000000000000e0 0 000000000000007c
1 001959b3 19 0000000000000007 0 000000000000007c
2 0129ea33 20 00000000000000e7 0 000000000000007c
0 00708013  0 0000000000000000 0 000000000000007c
0 00100ab3 21 0000000000000005 0 000000000000007c
0 abcde037  0 0000000000000000 0 000000000000007c
0 00000b33 22 0000000000000000 0 000000000000007c
0 00000000  0 0000000000000000 1 000000000000007c
0 00309093  1 0000000000000000 1 000000000000007c
0 4010f133  2 0000000000000000 1 000000000000007c
0 00208bb3 23 0000000000000002 0 000000000000007c
0 0000056f 10 0000000000000000 1 000000000000007c
0 00150513 10 000000000000007d 0 000000000000007d
0 40a00533 10 ffffffffffffff83 0 ffffffffffffff83
0 00d54c33 24 0000000000000004 0 ffffffffffffff83

// ==== core_tb.sv ====
`include "core_defines.svh"

module core_tb import rv_isa_pkg::*, core_pipe_pkg::*;;

    logic    clk;
    logic    rst_i;
    logic    instr_valid_i;
    instr_t  instr_i;
    xlen_t   pc_o;
    logic    commit_valid_o;
    commit_t commit_o;
    xlen_t   a0_o;

    commit_t exp_q[$];                      // expected retires, oldest first
    xlen_t   a0_q[$];
    int      gap_q[$];
    instr_t  instr_q[$];
    int      gap_sum;
    int      n_tests;
    bit      loaded;

    int      err_count;
    int      bad_tests;
    int      tests_done;
    int      commits_seen;
    int      base_errs;                     // err_count when the current test began
    int      cur_test;
    logic    a0_pending;
    xlen_t   a0_exp;

    core_top core_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_stimulus();
        int       fd;
        int       cnt;
        string    line;
        int       gap;
        instr_t   ins;
        reg_idx_t rdv;
        xlen_t    datav;
        logic     ill;
        xlen_t    a0v;
        xlen_t    exp_pc;
        commit_t  rec;
        exp_pc = `CORE_RESET_PC;
        fd = $fopen("core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open core_stimulus.txt for reading");
        end else begin
            while ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%d %h %d %h %d %h", gap, ins, rdv, datav, ill, a0v);
                if (cnt == 6) begin         // comment lines never parse
                    rec         = '0;
                    rec.pc      = exp_pc;
                    rec.instr   = ins;
                    rec.rd      = rdv;
                    rec.we      = !ill;     // illegal encodings write nothing
                    rec.data    = datav;
                    rec.illegal = ill;
                    exp_q.push_back(rec);
                    a0_q.push_back(a0v);
                    gap_q.push_back(gap);
                    instr_q.push_back(ins);
                    gap_sum = gap_sum + gap;
                    exp_pc  = exp_pc + xlen_t'(4);  // pcs step per instruction, not per cycle
                end
            end
            $fclose(fd);
        end
        n_tests = exp_q.size();
    endtask

    task automatic check_commit(input int idx, input commit_t got, input commit_t want);
        if (got.pc !== want.pc || got.instr !== want.instr || got.rd !== want.rd ||
            got.we !== want.we || got.data !== want.data ||
            got.illegal !== want.illegal) begin
            $display("Fail %0t: test %0d retired pc %h instr %h rd %0d we %b data %h illegal %b",
                     $time, idx, got.pc, got.instr, got.rd, got.we, got.data, got.illegal);
            $display("Fail %0t: test %0d expected pc %h instr %h rd %0d we %b data %h illegal %b",
                     $time, idx, want.pc, want.instr, want.rd, want.we, want.data, want.illegal);
            err_count++;
        end
    endtask

    task automatic check_a0(input int idx, input xlen_t got, input xlen_t want);
        if (got !== want) begin
            $display("Fail %0t: test %0d a0 is %h, expected %h", $time, idx, got, want);
            err_count++;
        end
    endtask

    task automatic check_pc(input xlen_t got, input xlen_t want);
        if (got !== want) begin
            $display("Fail %0t: fetch pc is %h, expected %h", $time, got, want);
            err_count++;
        end
    endtask

    task automatic report_test(input int idx);
        if (err_count == base_errs) begin
            $display("test %0d: ok", idx);
        end else begin
            $display("test %0d: mismatch", idx);
            bad_tests++;
        end
        tests_done++;
    endtask

    // sample on the falling edge, away from the drive edge
    initial begin
        commit_t want;
        xlen_t   pc_exp;
        pc_exp     = `CORE_RESET_PC;
        a0_pending = 1'b0;
        forever begin
            @(negedge clk);
            check_pc(pc_o, pc_exp);
            if (rst_i === 1'b0 && instr_valid_i === 1'b1) begin
                pc_exp = pc_exp + xlen_t'(4);   // taken at the coming edge
            end
            if (a0_pending) begin           // write of the previous retire has landed
                check_a0(cur_test, a0_o, a0_exp);
                report_test(cur_test);
                a0_pending = 1'b0;
            end
            if (commit_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: a commit arrived with no instruction outstanding", $time);
                    err_count++;
                end else begin
                    want      = exp_q.pop_front();
                    cur_test  = commits_seen;
                    base_errs = err_count;
                    commits_seen++;
                    check_commit(cur_test, commit_o, want);
                    a0_exp     = a0_q.pop_front();
                    a0_pending = 1'b1;
                end
            end
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = 8 * n_tests + gap_sum + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: only %0d of %0d instructions retired and were checked in %0d cycles",
                 tests_done, n_tests, limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        rst_i         <= 1'b1;
        load_stimulus();
        loaded = 1'b1;
        if (n_tests == 0) begin
            $display("no usable stimulus lines were found in core_stimulus.txt");
            $display("sim failed");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            rst_i <= 1'b0;
            foreach (instr_q[i]) begin
                repeat (gap_q[i]) begin
                    @(posedge clk);
                    instr_valid_i <= 1'b0;  // bubble
                end
                @(posedge clk);
                instr_valid_i <= 1'b1;
                instr_i       <= instr_q[i];
            end
            @(posedge clk);
            instr_valid_i <= 1'b0;
            wait (tests_done == n_tests);
            $display("%0d tests run, %0d with mismatches, %0d errors in total",
                     n_tests, bad_tests, err_count);
            if (err_count == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

// ==== core_top.sv ====
`include "core_defines.svh"

module core_top import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    instr_valid_i,
    input  instr_t  instr_i,
    output xlen_t   pc_o,
    output logic    commit_valid_o,
    output commit_t commit_o,
    output xlen_t   a0_o
);

    xlen_t      pc_q;
    fetch_pkt_t fetch_in;
    fetch_pkt_t id_pkt;
    logic       id_valid;
    exec_pkt_t  id_exec;
    exec_pkt_t  ex_pkt;
    logic       ex_valid;
    commit_t    ex_commit;
    commit_t    wb_pkt;
    logic       wb_valid;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      rs1_fwd;
    xlen_t      rs2_fwd;

    // pc only moves on an accepted instruction
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (instr_valid_i) begin
            pc_q <= pc_q + xlen_t'(4);
        end
    end

    assign pc_o     = pc_q;
    assign fetch_in = '{pc: pc_q, instr: instr_i};

    stage_reg #(.payload_t(fetch_pkt_t)) fetch_reg_u (
        .clk(clk), .rst_i(rst_i), .valid_i(instr_valid_i), .data_i(fetch_in),
        .valid_o(id_valid), .data_o(id_pkt)
    );

    decode_stage decode_u (
        .fetch_i(id_pkt), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .exec_o(id_exec)
    );

    regfile regfile_u (
        .clk(clk), .rst_i(rst_i),
        .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wr_en_i(wb_valid && wb_pkt.we), .wr_idx_i(wb_pkt.rd), .wr_data_i(wb_pkt.data),
        .a0_o(a0_o)
    );

    stage_reg #(.payload_t(exec_pkt_t)) exec_reg_u (
        .clk(clk), .rst_i(rst_i), .valid_i(id_valid), .data_i(id_exec),
        .valid_o(ex_valid), .data_o(ex_pkt)
    );

    forward_unit forward_u (
        .exec_i(ex_pkt), .wb_i(wb_pkt), .wb_valid_i(wb_valid),
        .rs1_val_o(rs1_fwd), .rs2_val_o(rs2_fwd)
    );

    alu_stage alu_u (
        .exec_i(ex_pkt), .rs1_val_i(rs1_fwd), .rs2_val_i(rs2_fwd), .commit_o(ex_commit)
    );

    stage_reg #(.payload_t(commit_t)) wb_reg_u (
        .clk(clk), .rst_i(rst_i), .valid_i(ex_valid), .data_i(ex_commit),
        .valid_o(wb_valid), .data_o(wb_pkt)
    );

    assign commit_valid_o = wb_valid;       // one retire per valid writeback
    assign commit_o       = wb_pkt;

endmodule

// ==== decode_stage.sv ====
`include "core_defines.svh"

module decode_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  fetch_pkt_t fetch_i,
    input  xlen_t      rs1_data_i,
    input  xlen_t      rs2_data_i,
    output reg_idx_t   rs1_idx_o,
    output reg_idx_t   rs2_idx_o,
    output exec_pkt_t  exec_o
);

    instr_t     instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;

    assign instr  = fetch_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(`CORE_XLEN-32){instr[31]}}, instr[31:12], 12'b0};  // sign-extended on rv64

    assign rs1_idx_o = instr[19:15];
    assign rs2_idx_o = instr[24:20];

    always_comb begin
        exec_o         = '0;
        exec_o.pc      = fetch_i.pc;
        exec_o.instr   = instr;
        exec_o.alu_op  = ALU_ADD;
        exec_o.rs1_val = rs1_data_i;
        exec_o.rs2_val = rs2_data_i;
        exec_o.rs1_idx = rs1_idx_o;
        exec_o.rs2_idx = rs2_idx_o;
        exec_o.rd_idx  = instr[11:7];
        exec_o.we      = 1'b1;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: exec_o.alu_op = ALU_ADD;
                    {F7_ALT,  F3_ADD_SUB}: exec_o.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLL}:     exec_o.alu_op = ALU_SLL;
                    {F7_BASE, F3_XOR}:     exec_o.alu_op = ALU_XOR;
                    {F7_BASE, F3_SRL}:     exec_o.alu_op = ALU_SRL;
                    {F7_BASE, F3_OR}:      exec_o.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     exec_o.alu_op = ALU_AND;
                    default:               exec_o.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                exec_o.use_imm = 1'b1;
                exec_o.imm     = imm_i;
                case (funct3)                   // shifts by imm not supported
                    F3_ADD_SUB: exec_o.alu_op = ALU_ADD;
                    F3_XOR:     exec_o.alu_op = ALU_XOR;
                    F3_OR:      exec_o.alu_op = ALU_OR;
                    F3_AND:     exec_o.alu_op = ALU_AND;
                    default:    exec_o.illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                exec_o.use_imm = 1'b1;
                exec_o.imm     = imm_u;
                exec_o.alu_op  = ALU_PASS_B;
            end
            default: exec_o.illegal = 1'b1;
        endcase
        if (exec_o.illegal) begin
            exec_o.we = 1'b0;               // illegal retires without a write
        end
    end

endmodule

// ==== forward_unit.sv ====
module forward_unit import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  exec_pkt_t exec_i,
    input  commit_t   wb_i,
    input  logic      wb_valid_i,
    output xlen_t     rs1_val_o,
    output xlen_t     rs2_val_o
);

    logic wb_writes;
    logic hit_rs1;
    logic hit_rs2;

    // only a valid, writing, non-x0 record can forward
    assign wb_writes = wb_valid_i && wb_i.we && (wb_i.rd != '0);

    assign hit_rs1 = wb_writes && (wb_i.rd == exec_i.rs1_idx);
    assign hit_rs2 = wb_writes && (wb_i.rd == exec_i.rs2_idx);

    assign rs1_val_o = hit_rs1 ? wb_i.data : exec_i.rs1_val;
    assign rs2_val_o = hit_rs2 ? wb_i.data : exec_i.rs2_val;

endmodule

// ==== regfile.sv ====
`include "core_defines.svh"

module regfile import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  xlen_t    wr_data_i,
    output xlen_t    a0_o
);

    xlen_t regs [1:`CORE_NREGS-1];          // x0 has no storage

    logic  wr_hit;

    assign wr_hit = wr_en_i && (wr_idx_i != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // write-through, decode sees the value being written this cycle
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                        (wr_hit && wr_idx_i == rs1_idx_i) ? wr_data_i : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                        (wr_hit && wr_idx_i == rs2_idx_i) ? wr_data_i : regs[rs2_idx_i];

    assign a0_o = regs[10];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module core_tb
./obj_dir/Vcore_tb | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "run_sim: simulation reported success"
else
    echo "run_sim: simulation did not report success"
    exit 1
fi

// ==== rv_isa_pkg.sv ====
`include "core_defines.svh"

package rv_isa_pkg;

    typedef logic [`CORE_XLEN-1:0]            xlen_t;
    typedef logic [`CORE_ILEN-1:0]            instr_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0]   reg_idx_t;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,            // reg-reg
        OPC_OP_IMM = 7'b0010011,            // reg-imm
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;  // sub

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B                          // lui, operand b straight through
    } alu_op_e;

endpackage

// ==== stage_reg.sv ====
module stage_reg import rv_isa_pkg::*; #(
    parameter type payload_t = xlen_t
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;             // bubbles pass through as valid low
        end
    end

    // payload is don't-care while valid is low
    always_ff @(posedge clk) begin
        data_o <= data_i;
    end

endmodule

// ==== verilog.f ====
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
stage_reg.sv
regfile.sv
decode_stage.sv
forward_unit.sv
alu_stage.sv
core_top.sv
core_props.sv
core_tb.sv
